// ==== m68k_bus.f ====
verilog/m68k_bus_pkg.sv
verilog/m68k_map_pkg.sv
verilog/m68k_bus_adapter.sv
verilog/m68k_cmd_engine.sv
verilog/m68k_ram_slave.sv
verilog/m68k_bus_top.sv
testbench/tb_clock_gen.sv
testbench/tb_m68k_bus.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_m68k_bus
FILELIST  = m68k_bus.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -Fqx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_m68k_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_m68k_bus;

    localparam logic [1:0] ACT_NONE = 2'd0;
    localparam logic [1:0] ACT_HALT = 2'd1;     // halt_n low around the command
    localparam logic [1:0] ACT_BREQ = 2'd2;     // br_n low before the command
    localparam int NUM_TESTS   = 16;
    localparam int HOLD_CYCLES = 20;            // Stall length for halt and grant
    localparam int CYCLE_LIMIT = NUM_TESTS * (m68k_map_pkg::BUS_TIMEOUT + 16);

    typedef struct packed {
        logic              write;
        logic [1:0]        be;                  // {upper, lower}
        m68k_bus_pkg::fc_t fc;
        logic [31:0]       addr;
        logic              exp_err;
        logic [15:0]       exp_data;            // Only for rows nobody answers
        logic [1:0]        act;
    } test_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        '{1'b1, 2'b11, m68k_bus_pkg::FC_SUP_DATA,  32'h0000_0010, 1'b0, 16'h0, ACT_NONE},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_SUP_DATA,  32'h0000_0010, 1'b0, 16'h0, ACT_NONE},
        '{1'b1, 2'b11, m68k_bus_pkg::FC_USER_DATA, 32'h0000_01fe, 1'b0, 16'h0, ACT_NONE},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_USER_PROG, 32'h0000_01fe, 1'b0, 16'h0, ACT_NONE},
        '{1'b1, 2'b11, m68k_bus_pkg::FC_SUP_DATA,  32'h0010_0020, 1'b0, 16'h0, ACT_NONE},
        '{1'b1, 2'b10, m68k_bus_pkg::FC_USER_DATA, 32'h0010_0020, 1'b0, 16'h0, ACT_NONE},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_USER_DATA, 32'h0010_0020, 1'b0, 16'h0, ACT_NONE},
        '{1'b1, 2'b01, m68k_bus_pkg::FC_SUP_DATA,  32'h0010_0020, 1'b0, 16'h0, ACT_NONE},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_SUP_PROG,  32'h0010_0020, 1'b0, 16'h0, ACT_NONE},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_USER_DATA, 32'h0008_0000, 1'b1, 16'h0, ACT_NONE},
        '{1'b1, 2'b11, m68k_bus_pkg::FC_SUP_DATA,  32'h0000_0200, 1'b1, 16'h0, ACT_NONE},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_SUP_DATA,  32'h0000_0010, 1'b0, 16'h0, ACT_BREQ},
        '{1'b1, 2'b11, m68k_bus_pkg::FC_USER_DATA, 32'h0010_0040, 1'b0, 16'h0, ACT_HALT},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_USER_PROG, 32'h0010_0040, 1'b0, 16'h0, ACT_HALT},
        '{1'b1, 2'b11, m68k_bus_pkg::FC_SUP_PROG,  32'h0000_0012, 1'b0, 16'h0, ACT_BREQ},
        '{1'b0, 2'b11, m68k_bus_pkg::FC_SUP_DATA,  32'h0000_0012, 1'b0, 16'h0, ACT_NONE}
    };

    logic                   clk;
    logic                   rst;
    logic                   halt_n;
    logic                   br_n;
    logic                   bgack_n;
    logic                   bg_n;
    logic                   cmd_valid;
    m68k_bus_pkg::bus_cmd_t cmd;
    logic                   cmd_ready;
    logic                   rsp_valid;
    m68k_bus_pkg::bus_rsp_t rsp;
    m68k_bus_pkg::fc_t      fc;
    logic                   as_n;

    logic [15:0] ref_mem [logic [22:0]];        // Reference RAM, keyed by word address
    integer      seed;
    int          err_cnt;
    int          pass_cnt;
    int          cycle_cnt;

    tb_clock_gen u_clk (
        .clk ( clk ),
        .rst ( rst )
    );

    m68k_bus_top uut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .halt_n    ( halt_n    ),
        .br_n      ( br_n      ),
        .bgack_n   ( bgack_n   ),
        .bg_n      ( bg_n      ),
        .cmd_valid ( cmd_valid ),
        .cmd       ( cmd       ),
        .cmd_ready ( cmd_ready ),
        .rsp_valid ( rsp_valid ),
        .rsp       ( rsp       ),
        .fc        ( fc        ),
        .as_n      ( as_n      )
    );

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic run_test(input int n);
        test_t                  t;
        m68k_bus_pkg::bus_cmd_t c;
        logic [15:0]            wdata;
        logic [15:0]            exp_data;
        logic [22:0]            widx;
        logic                   seen_as;
        int                     errs_before;
        t           = TESTS[n];
        errs_before = err_cnt;
        seen_as     = 1'b0;
        widx        = t.addr[23:1];
        wdata       = t.write ? 16'($random(seed)) : 16'h0000;
        c.write     = t.write;
        c.byte_ena  = t.be;
        c.fc        = t.fc;
        c.addr      = t.addr;
        c.wr_data   = wdata;
        c.rsvd      = '0;
        if (t.exp_err) exp_data = t.exp_data;     // No slave, data forced to zero
        else if (t.write) exp_data = 16'h0000;    // Writes return no data
        else exp_data = ref_mem.exists(widx) ? ref_mem[widx] : 16'hxxxx;

        @(negedge clk);
        if (t.act == ACT_HALT) halt_n = 1'b0;
        if (t.act == ACT_BREQ) begin
            br_n = 1'b0;
            @(negedge clk);
            compare(32'(bg_n), 32'd0, "bg_n one cycle after br_n");
        end
        cmd       = c;
        cmd_valid = 1'b1;
        while (!cmd_ready) @(negedge clk);       // Handshake lands on next rising edge
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = '0;

        if (t.act != ACT_NONE) begin
            repeat (HOLD_CYCLES) begin
                compare(32'(rsp_valid), 32'd0, "rsp_valid during stall");
                compare(32'(as_n), 32'd1, "as_n during stall");
                if (t.act == ACT_BREQ) compare(32'(bg_n), 32'd0, "bg_n during request");
                @(negedge clk);
            end
            halt_n = 1'b1;
            if (t.act == ACT_BREQ) begin
                br_n = 1'b1;
                @(negedge clk);
                compare(32'(bg_n), 32'd1, "bg_n one cycle after release");
            end
        end

        while (!rsp_valid) begin
            if (!as_n) begin
                seen_as = 1'b1;
                compare(32'(fc), 32'(t.fc), "fc pins during as_n low");
            end
            @(negedge clk);
        end
        compare(32'(seen_as), 32'd1, "as_n went low");
        compare(32'(rsp.bus_err), 32'(t.exp_err), "bus error flag");
        compare(32'(rsp.write), 32'(t.write), "response write flag");
        compare(32'(rsp.rd_data), 32'(exp_data), "read data");
        compare(32'(cmd_ready), 32'd1, "cmd_ready after response");

        if (t.write && !t.exp_err) begin
            if (!ref_mem.exists(widx)) ref_mem[widx] = 16'hxxxx;
            if (t.be[1]) ref_mem[widx][15:8] = wdata[15:8];  // Lane by lane
            if (t.be[0]) ref_mem[widx][7:0]  = wdata[7:0];
        end
        if (err_cnt == errs_before) pass_cnt = pass_cnt + 1;
        $display("test %2d %s %h: %s", n, t.write ? "write" : "read ", t.addr,
                 (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    // Watchdog on the whole run
    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= CYCLE_LIMIT) begin
                $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    initial begin
        seed      = 32'hc805_e9b8;
        err_cnt   = 0;
        pass_cnt  = 0;
        cycle_cnt = 0;
        halt_n    = 1'b1;
        br_n      = 1'b1;
        bgack_n   = 1'b1;                         // Never asserted
        cmd_valid = 1'b0;
        cmd       = '0;

        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (2) @(negedge clk);
        compare(32'(cmd_ready), 32'd1, "cmd_ready after reset");
        compare(32'(rsp_valid), 32'd0, "rsp_valid after reset");
        compare(32'(as_n), 32'd1, "as_n after reset");
        compare(32'(bg_n), 32'd1, "bg_n after reset");

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, pass_cnt, NUM_TESTS - pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int PERIOD       = 100;          // ns
    localparam int RESET_CYCLES = 16;

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;                              // Released on a falling edge
    end

endmodule

`default_nettype wire

// ==== verilog/m68k_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module m68k_bus_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   halt_n,
    input  wire logic                   br_n,
    input  wire logic                   bgack_n,
    output logic                        bg_n,
    input  wire logic                   cmd_valid,
    input  wire m68k_bus_pkg::bus_cmd_t cmd,
    output logic                        cmd_ready,
    output logic                        rsp_valid,
    output m68k_bus_pkg::bus_rsp_t      rsp,
    output m68k_bus_pkg::fc_t           fc,
    output logic                        as_n
);

    m68k_bus_pkg::core_bus_t core;               // Engine strobes
    logic        cen;
    logic        data_ack;
    logic        abort;
    logic [15:0] rd_data;
    logic [23:1] eab;
    logic        uds_n;
    logic        lds_n;
    logic        rw_n;
    logic        dtack_n;
    logic [15:0] edb_in;                         // Slave to master
    logic [15:0] edb_out;                        // Master to slave

    m68k_cmd_engine u_engine (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cmd_valid ( cmd_valid ),
        .cmd       ( cmd       ),
        .cmd_ready ( cmd_ready ),
        .rsp_valid ( rsp_valid ),
        .rsp       ( rsp       ),
        .cen       ( cen       ),
        .data_ack  ( data_ack  ),
        .rd_data   ( rd_data   ),
        .core      ( core      ),
        .abort     ( abort     )
    );

    m68k_bus_adapter u_adapter (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .halt_n   ( halt_n   ),
        .br_n     ( br_n     ),
        .bgack_n  ( bgack_n  ),
        .core     ( core     ),
        .abort    ( abort    ),
        .cen      ( cen      ),
        .data_ack ( data_ack ),
        .rd_data  ( rd_data  ),
        .eab      ( eab      ),
        .as_n     ( as_n     ),
        .uds_n    ( uds_n    ),
        .lds_n    ( lds_n    ),
        .rw_n     ( rw_n     ),
        .dtack_n  ( dtack_n  ),
        .edb_in   ( edb_in   ),
        .edb_out  ( edb_out  ),
        .bg_n     ( bg_n     ),
        .fc       ( fc       )
    );

    m68k_ram_slave u_slave (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .eab     ( eab     ),
        .as_n    ( as_n    ),
        .uds_n   ( uds_n   ),
        .lds_n   ( lds_n   ),
        .rw_n    ( rw_n    ),
        .edb_out ( edb_out ),
        .edb_in  ( edb_in  ),
        .dtack_n ( dtack_n )
    );

endmodule

`default_nettype wire

// ==== verilog/m68k_ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module m68k_ram_slave (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [23:1] eab,
    input  wire logic        as_n,
    input  wire logic        uds_n,
    input  wire logic        lds_n,
    input  wire logic        rw_n,
    input  wire logic [15:0] edb_out,
    output logic [15:0]      edb_in,
    output logic             dtack_n
);

    logic [15:0] fast_mem [m68k_map_pkg::RAM_WORDS];  // Zero-wait window
    logic [15:0] slow_mem [m68k_map_pkg::RAM_WORDS];  // Slow window
    logic [23:0] byte_addr;
    logic [23:0] fast_off;
    logic [23:0] slow_off;
    logic        in_fast;
    logic        in_slow;
    logic [$clog2(m68k_map_pkg::RAM_WORDS)-1:0] idx;
    logic [3:0]  region_wait;
    logic [3:0]  wcnt;                            // Cycles AS has been low
    logic        ack_q;
    logic        go;
    logic        expire;

    assign byte_addr = {eab, 1'b0};
    assign fast_off  = byte_addr - m68k_map_pkg::RAM_BASE;
    assign slow_off  = byte_addr - m68k_map_pkg::SLOW_BASE;
    assign in_fast   = (byte_addr >= m68k_map_pkg::RAM_BASE) &&
                       (fast_off < m68k_map_pkg::REGION_SIZE);
    assign in_slow   = (byte_addr >= m68k_map_pkg::SLOW_BASE) &&
                       (slow_off < m68k_map_pkg::REGION_SIZE);
    assign idx = in_fast ? fast_off[$clog2(m68k_map_pkg::RAM_WORDS):1]
                         : slow_off[$clog2(m68k_map_pkg::RAM_WORDS):1];
    assign region_wait = in_fast ? 4'(m68k_map_pkg::FAST_WAIT)
                                 : 4'(m68k_map_pkg::SLOW_WAIT);

    // Unmapped space never counts, so it never acks
    assign go     = ~as_n & ~ack_q & (in_fast | in_slow);
    assign expire = go & (wcnt == region_wait);

    // Released as soon as the master lifts AS
    assign dtack_n = ~(ack_q & ~as_n);

    always_ff @(posedge clk) begin
        if (rst) begin
            wcnt  <= 4'd0;
            ack_q <= 1'b0;
        end else if (as_n) begin
            wcnt  <= 4'd0;                        // Idle bus, rearm
            ack_q <= 1'b0;
        end else begin
            if (go) wcnt <= wcnt + 4'd1;
            if (expire) ack_q <= 1'b1;            // Held until AS rises
        end
    end

    // Storage, touched once per cycle when the wait expires
    always_ff @(posedge clk) begin
        if (expire && !rw_n) begin
            if (in_fast) begin
                if (!uds_n) fast_mem[idx][15:8] <= edb_out[15:8];
                if (!lds_n) fast_mem[idx][7:0]  <= edb_out[7:0];
            end else begin
                if (!uds_n) slow_mem[idx][15:8] <= edb_out[15:8];
                if (!lds_n) slow_mem[idx][7:0]  <= edb_out[7:0];
            end
        end
        if (expire && rw_n) begin
            edb_in <= in_fast ? fast_mem[idx] : slow_mem[idx];  // Valid with DTACK
        end
    end

    // DTACK never answers unmapped space
    a_dtack_mapped: assert property (@(posedge clk) disable iff (rst)
        !dtack_n |-> in_fast || in_slow);

endmodule

`default_nettype wire

// ==== verilog/m68k_cmd_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module m68k_cmd_engine (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     cmd_valid,
    input  wire m68k_bus_pkg::bus_cmd_t   cmd,
    output logic                          cmd_ready,
    output logic                          rsp_valid,
    output m68k_bus_pkg::bus_rsp_t        rsp,
    input  wire logic                     cen,
    input  wire logic                     data_ack,
    input  wire logic [15:0]              rd_data,
    output m68k_bus_pkg::core_bus_t       core,
    output logic                          abort
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,                         // Ready for a command
        ST_STROBE = 2'd1,                         // Waiting for cen to launch
        ST_WAIT   = 2'd2                          // Cycle out, waiting for DTACK
    } state_t;

    state_t                 state;
    m68k_bus_pkg::bus_cmd_t cmd_q;                // Held for the whole bus cycle
    logic [$clog2(m68k_map_pkg::BUS_TIMEOUT)-1:0] wd_cnt;
    logic                   launch;
    logic                   wd_hit;

    assign cmd_ready = (state == ST_IDLE);
    assign launch    = (state == ST_STROBE) & cen;  // Exactly one cen wide
    assign wd_hit    = wd_cnt ==
        ($clog2(m68k_map_pkg::BUS_TIMEOUT))'(m68k_map_pkg::BUS_TIMEOUT - 1);

    // A late DTACK in the last cycle still wins over the watchdog
    assign abort = (state == ST_WAIT) & wd_hit & ~data_ack;

    assign core.rd_ena   = launch & ~cmd_q.write;
    assign core.wr_ena   = launch & cmd_q.write;
    assign core.byte_ena = cmd_q.byte_ena;
    assign core.fc       = cmd_q.fc;
    assign core.address  = cmd_q.addr;
    assign core.wr_data  = cmd_q.wr_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b0;
            wd_cnt    <= '0;
        end else begin
            rsp_valid <= 1'b0;                    // Single-cycle pulse
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) state <= ST_STROBE;
                end
                ST_STROBE: begin
                    wd_cnt <= '0;
                    if (cen) state <= ST_WAIT;
                end
                ST_WAIT: begin
                    wd_cnt <= wd_cnt + 1'b1;
                    if (data_ack || abort) begin
                        state     <= ST_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command and response payload
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) cmd_q <= cmd;
        if (state == ST_WAIT && data_ack) begin
            rsp.rd_data <= cmd_q.write ? 16'h0000 : rd_data;  // Sample on DTACK
            rsp.bus_err <= 1'b0;
            rsp.write   <= cmd_q.write;
        end else if (abort) begin
            rsp.rd_data <= 16'h0000;
            rsp.bus_err <= 1'b1;                  // Bus error, nobody answered
            rsp.write   <= cmd_q.write;
        end
    end

    // DTACK only answers the cycle in flight
    a_ack_in_wait: assert property (@(posedge clk) disable iff (rst)
        data_ack |-> state == ST_WAIT);

endmodule

`default_nettype wire

// ==== verilog/m68k_bus_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module m68k_bus_adapter (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    halt_n,
    input  wire logic                    br_n,
    input  wire logic                    bgack_n,  // Pin only, nothing behind it
    input  wire m68k_bus_pkg::core_bus_t core,
    input  wire logic                    abort,     // Watchdog drop from engine
    output logic                         cen,
    output logic                         data_ack,
    output logic [15:0]                  rd_data,
    output logic [23:1]                  eab,
    output logic                         as_n,
    output logic                         uds_n,
    output logic                         lds_n,
    output logic                         rw_n,
    input  wire logic                    dtack_n,
    input  wire logic [15:0]             edb_in,
    output logic [15:0]                  edb_out,
    output logic                         bg_n,
    output m68k_bus_pkg::fc_t            fc
);

    logic cen_q;                                 // Free divide-by-two phase
    logic bus_busy;                              // Holds AS after the strobe
    logic busy_wr;                               // Direction of cycle in flight
    logic strobe;
    logic bus_act;

    assign strobe   = core.rd_ena | core.wr_ena;
    assign bus_act  = strobe | bus_busy;
    assign as_n     = ~bus_act;                  // Drops with the strobe itself
    assign uds_n    = ~(core.byte_ena[1] & bus_act);  // Lanes only inside a cycle
    assign lds_n    = ~(core.byte_ena[0] & bus_act);
    assign rw_n     = ~(core.wr_ena | (bus_busy & busy_wr));
    assign eab      = core.address[23:1];        // Word address, A0 dropped
    assign edb_out  = core.wr_data;
    assign rd_data  = edb_in;
    assign data_ack = ~dtack_n;
    assign fc       = core.fc;

    // Halt or grant freezes the enable right away
    assign cen = cen_q & halt_n & bg_n;

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_q <= 1'b0;
        end else begin
            cen_q <= ~cen_q & halt_n & bg_n;      // Restart phase after a stall
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_busy <= 1'b0;
            busy_wr  <= 1'b0;
        end else begin
            if (strobe) begin
                bus_busy <= 1'b1;
                busy_wr  <= core.wr_ena;         // Keep R/W through wait states
            end else if (data_ack || abort) begin
                bus_busy <= 1'b0;
            end
        end
    end

    // Grant only with AS high; release follows BR directly
    always_ff @(posedge clk) begin
        if (rst) begin
            bg_n <= 1'b1;
        end else if (br_n) begin
            bg_n <= 1'b1;
        end else if (as_n) begin
            bg_n <= 1'b0;
        end
    end

    // A granted bus never carries a cycle
    a_grant_idle: assert property (@(posedge clk) disable iff (rst)
        !bg_n |-> as_n);

endmodule

`default_nettype wire

// ==== verilog/m68k_map_pkg.sv ====
`default_nettype none

package m68k_map_pkg;

    // Two mapped windows, everything else is unmapped
    localparam logic [23:0] RAM_BASE    = 24'h00_0000;  // Fast RAM
    localparam logic [23:0] SLOW_BASE   = 24'h10_0000;  // Slow RAM
    localparam logic [23:0] REGION_SIZE = 24'h00_0200;  // 512 bytes each

    localparam int RAM_WORDS = 256;             // Words per region

    // Wait states inserted before DTACK
    localparam int FAST_WAIT = 0;
    localparam int SLOW_WAIT = 3;

    localparam int BUS_TIMEOUT = 32;            // Watchdog cycles in wait

endpackage

`default_nettype wire

// ==== verilog/m68k_bus_pkg.sv ====
`default_nettype none

package m68k_bus_pkg;

    typedef logic [2:0] fc_t;                   // 68000 FC2..FC0

    localparam fc_t FC_USER_DATA = 3'd1;        // User data space
    localparam fc_t FC_USER_PROG = 3'd2;        // User program space
    localparam fc_t FC_SUP_DATA  = 3'd5;        // Supervisor data
    localparam fc_t FC_SUP_PROG  = 3'd6;        // Supervisor program

    // Command word on the valid/ready port
    typedef struct packed {
        logic        write;                     // 1 = write, 0 = read
        logic [1:0]  byte_ena;                  // {upper, lower}
        fc_t         fc;
        logic [31:0] addr;                      // Byte address
        logic [15:0] wr_data;
        logic [5:0]  rsvd;                      // Keep zero
    } bus_cmd_t;

    // Response, one pulse per command
    typedef struct packed {
        logic [15:0] rd_data;                   // Zero on writes and errors
        logic        bus_err;                   // Watchdog expired
        logic        write;                     // Echo of command type
    } bus_rsp_t;

    // Core-side strobe bundle, same shape as a 68000 core's bus port
    typedef struct packed {
        logic        rd_ena;                    // Read strobe, one cen cycle
        logic        wr_ena;                    // Write strobe, one cen cycle
        logic [1:0]  byte_ena;
        fc_t         fc;
        logic [31:0] address;
        logic [15:0] wr_data;
    } core_bus_t;

endpackage

`default_nettype wire
